/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = pipe_ctrl_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
PASS_MSG  = Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/pipe_ctrl_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module pipe_ctrl_tb import core_pkg::*; ;

   logic                clk;
   logic                rstn;
   stage_flags_t        stage_done;
   instr_desc_t         dec_desc, exe_desc, mem_desc;
   operand_pair_t       dec_regs, dec_fregs;
   logic [`XLEN_W-1:0]  exe_result, mem_result;
   jump_t               exe_jump;
   logic [`XLEN_W-1:0]  pc;
   stage_flags_t        stage_valid, stage_start;
   operand_pair_t       exe_operands, exe_foperands;
   logic [`COUNT_W-1:0] retired;

   integer              seed = 67;
   int                  errors, checks;
   int                  ev [string];

   // reference model state
   logic [`XLEN_W-1:0]  m_pc;
   stage_flags_t        m_valid, m_start;
   logic                m_stall, m_ops_known;
   logic [`COUNT_W-1:0] m_retired;
   operand_pair_t       m_ops, m_fops;

   tb_clock u_clk (.clk(clk));

   pipe_ctrl_top UUT (
      .clk(clk), .rstn(rstn), .stage_done(stage_done),
      .dec_desc(dec_desc), .exe_desc(exe_desc), .mem_desc(mem_desc),
      .dec_regs(dec_regs), .dec_fregs(dec_fregs),
      .exe_result(exe_result), .mem_result(mem_result), .exe_jump(exe_jump),
      .pc(pc), .stage_valid(stage_valid), .stage_start(stage_start),
      .exe_operands(exe_operands), .exe_foperands(exe_foperands), .retired(retired)
   );

   function automatic logic [31:0] next_word();
      return $random(seed);
   endfunction

   // true with probability 1/(mask+1)
   function automatic logic chance(input logic [31:0] mask);
      logic [31:0] w;
      w = next_word();
      return (w & mask) == 32'd0;
   endfunction

   // register numbers 0..3 keep hazards frequent
   function automatic instr_desc_t make_desc(input logic haz, input logic load, input logic jump);
      instr_desc_t d;
      logic [31:0] sel;
      d.pc = next_word() & ~32'd3;
      d.imm = next_word();
      d.rd = 5'(next_word() & 32'd3);
      d.rs1 = 5'(next_word() & 32'd3);
      d.rs2 = 5'(next_word() & 32'd3);
      d.uses_reg = haz && chance(32'd1);
      d.writes_reg = chance(32'd1);
      d.uses_freg = haz && chance(32'd1);
      d.writes_freg = chance(32'd1);
      d.is_load = load && chance(32'd3);
      sel = next_word() & 32'd7;
      d.jal = jump && sel == 32'd0;
      d.jalr = jump && sel == 32'd1;
      return d;
   endfunction

   task automatic drive_inputs(input int mode);
      logic jump;
      jump = (mode == 3 || mode == 4);
      for (int i = 0; i < 5; i++) stage_done[i] = !chance(32'd7);
      dec_desc = make_desc(mode != 0, 1'b0, jump);
      exe_desc = make_desc(1'b0, mode == 2 || mode == 4, jump);
      mem_desc = make_desc(1'b0, 1'b0, 1'b0);
      dec_regs = {next_word(), next_word()};
      dec_fregs = {next_word(), next_word()};
      exe_result = next_word();
      mem_result = next_word();
      exe_jump.taken = jump && chance(32'd3);
      exe_jump.dest = next_word() & ~32'd3;
   endtask

   task automatic resolve_operand(input logic one, input logic two, input logic ex_av,
      input logic mem_av, input logic [4:0] rs, input logic [31:0] rf,
      output logic [31:0] val, output int src);
      if (one && ex_av && exe_desc.rd == rs) begin
         val = exe_result;
         src = 1;
      end else if (two && mem_av && mem_desc.rd == rs) begin
         val = mem_result;
         src = 2;
      end else begin
         val = rf;
         src = 0;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////
   // reference model, one call per rising edge
   ////////////////////////////////////////////////////////////////////////
   task automatic update_model();
      logic ex_av, mem_av, all_done, load_use, pred_avail, redirect, latch;
      logic int_one, int_two, fp_one, fp_two;
      logic [31:0] pred_pc, next_pc;
      operand_pair_t ops, fops;
      int src [4];
      ctrl_action_e act;
      stage_flags_t nv;
      if (rstn) begin
         m_pc = `XLEN_W'(`RESET_PC);
         m_valid = '{fetch: 1'b1, default: 1'b0};
         m_start = '{fetch: 1'b1, default: 1'b0};
         m_stall = 1'b0;
         m_retired = '0;
         m_ops_known = 1'b0;
      end else begin
         all_done = 1'b1;
         for (int i = 0; i < 5; i++) if (m_valid[i] && !stage_done[i]) all_done = 1'b0;
         ex_av = m_valid.exec && stage_done.exec;
         mem_av = m_valid.mem && stage_done.mem;
         int_one = dec_desc.uses_reg && exe_desc.writes_reg && exe_desc.rd != '0
                   && (exe_desc.rd == dec_desc.rs1 || exe_desc.rd == dec_desc.rs2);
         int_two = dec_desc.uses_reg && mem_desc.writes_reg && mem_desc.rd != '0
                   && (mem_desc.rd == dec_desc.rs1 || mem_desc.rd == dec_desc.rs2);
         fp_one = dec_desc.uses_freg && exe_desc.writes_freg
                  && (exe_desc.rd == dec_desc.rs1 || exe_desc.rd == dec_desc.rs2);
         fp_two = dec_desc.uses_freg && mem_desc.writes_freg
                  && (mem_desc.rd == dec_desc.rs1 || mem_desc.rd == dec_desc.rs2);
         resolve_operand(int_one, int_two, ex_av, mem_av, dec_desc.rs1, dec_regs.rs1, ops.rs1, src[0]);
         resolve_operand(int_one, int_two, ex_av, mem_av, dec_desc.rs2, dec_regs.rs2, ops.rs2, src[1]);
         resolve_operand(fp_one, fp_two, ex_av, mem_av, dec_desc.rs1, dec_fregs.rs1, fops.rs1, src[2]);
         resolve_operand(fp_one, fp_two, ex_av, mem_av, dec_desc.rs2, dec_fregs.rs2, fops.rs2, src[3]);
         load_use = exe_desc.is_load && ex_av && (int_one || fp_one);
         pred_avail = m_valid.decode && stage_done.decode && (dec_desc.jal || dec_desc.jalr);
         pred_pc = (dec_desc.jalr ? ops.rs1 : dec_desc.pc) + dec_desc.imm;
         redirect = ex_av && exe_jump.taken && !(exe_desc.jal || exe_desc.jalr);
         if (m_stall) act = act_stall_release;
         else if (load_use) act = act_load_stall;
         else if (redirect) act = act_redirect;
         else if (pred_avail) act = act_predict;
         else act = act_advance;
         if (all_done) begin
            nv = m_valid;
            nv.fetch = 1'b1;
            nv.mem = ex_av;
            nv.write = mem_av;
            next_pc = m_pc + `XLEN_W'(`PC_STEP);
            latch = (act != act_load_stall) && (act != act_redirect);
            case (act)
               act_stall_release: begin
                  nv.decode = !dec_desc.jalr;
                  nv.exec = 1'b1;
                  if (dec_desc.jalr) next_pc = pred_pc;
                  ev["release"]++;
               end
               act_load_stall: begin
                  next_pc = m_pc;
                  nv.decode = 1'b1;
                  nv.exec = 1'b0;
                  ev["stall"]++;
               end
               act_redirect: begin
                  next_pc = exe_jump.dest;
                  nv.decode = 1'b0;
                  nv.exec = 1'b0;
                  ev["redirect"]++;
               end
               act_predict: begin
                  next_pc = pred_pc;
                  nv.decode = 1'b0;
                  nv.exec = 1'b1;
                  ev["predict"]++;
                  if (dec_desc.jalr) ev["jalr"]++;
               end
               default: begin
                  nv.decode = stage_done.fetch;
                  nv.exec = stage_done.decode && m_valid.decode;
               end
            endcase
            if (latch) begin
               m_ops = ops;
               m_fops = fops;
               m_ops_known = 1'b1;
               if (src[0] == 1 || src[1] == 1 || src[2] == 1 || src[3] == 1) ev["fwd_exe"]++;
               if (src[0] == 2 || src[1] == 2 || src[2] == 2 || src[3] == 2) ev["fwd_mem"]++;
               if ((src[2] != 0 && dec_desc.rs1 == '0) || (src[3] != 0 && dec_desc.rs2 == '0))
                  ev["f0"]++;
               if (dec_desc.uses_reg && exe_desc.writes_reg && exe_desc.rd == '0 && ex_av
                   && (dec_desc.rs1 == '0 || dec_desc.rs2 == '0))
                  ev["x0"]++;
            end
            if (m_valid.write) begin
               m_retired = m_retired + 1;
               ev["retire"]++;
            end
            m_start = nv;
            m_start.fetch = (act != act_load_stall);
            m_valid = nv;
            m_pc = next_pc;
            m_stall = (act == act_load_stall);
            ev["adv"]++;
         end else begin
            m_start = '0;
            ev["hold"]++;
         end
      end
   endtask

   task automatic compare_word(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic compare_flags(input string what, input stage_flags_t got, input stage_flags_t exp);
      checks++;
      assert (got === exp) else begin
         $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic step_cycle();
      @(posedge clk);
      update_model();
      @(negedge clk);
      compare_word("pc", pc, m_pc);
      compare_flags("stage_valid", stage_valid, m_valid);
      compare_flags("stage_start", stage_start, m_start);
      compare_word("retired", retired, m_retired);
      if (m_ops_known) begin
         compare_word("exe_operands.rs1", exe_operands.rs1, m_ops.rs1);
         compare_word("exe_operands.rs2", exe_operands.rs2, m_ops.rs2);
         compare_word("exe_foperands.rs1", exe_foperands.rs1, m_fops.rs1);
         compare_word("exe_foperands.rs2", exe_foperands.rs2, m_fops.rs2);
      end
   endtask

   function automatic logic goal_met(input int mode);
      case (mode)
         0: return ev["adv"] >= 30 && ev["hold"] >= 10;
         1: return ev["fwd_exe"] >= 5 && ev["fwd_mem"] >= 5 && ev["f0"] >= 1 && ev["x0"] >= 1;
         2: return ev["stall"] >= 3 && ev["release"] >= 3;
         3: return ev["predict"] >= 3 && ev["jalr"] >= 1 && ev["redirect"] >= 3;
         default: return ev["retire"] >= 40;
      endcase
   endfunction

   // every test is a wait loop bounded by limit cycles
   task automatic run_test(input string name, input int mode, input int limit);
      int cycles, e0, c0;
      ev.delete();
      e0 = errors;
      c0 = checks;
      cycles = 0;
      while (!goal_met(mode) && cycles < limit) begin
         drive_inputs(mode);
         step_cycle();
         cycles++;
      end
      if (!goal_met(mode)) begin
         $display("timeout: %s did not reach its goal within %0d cycles", name, limit);
         errors++;
      end
      $display("%s: %0d cycles, %0d checks, %0d errors", name, cycles, checks - c0, errors - e0);
   endtask

   initial begin
      rstn = 1'b1;
      stage_done = '0;
      dec_desc = '0;
      exe_desc = '0;
      mem_desc = '0;
      dec_regs = '0;
      dec_fregs = '0;
      exe_result = '0;
      mem_result = '0;
      exe_jump = '0;
      errors = 0;
      checks = 0;
      repeat (5) step_cycle();
      rstn = 1'b0;
      compare_word("pc after reset", pc, 32'd0);
      compare_flags("valid after reset", stage_valid, 5'b10000);
      compare_flags("start after reset", stage_start, 5'b10000);
      compare_word("retired after reset", retired, 32'd0);
      $display("reset: %0d checks, %0d errors", checks, errors);
      run_test("sequential", 0, 2000);
      run_test("forwarding", 1, 4000);
      run_test("load_use", 2, 4000);
      run_test("jumps", 3, 4000);
      run_test("retired", 4, 4000);
      $display("total: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
   parameter real PERIOD = 8.0
) (
   output logic clk
);

   initial clk = 1'b0;

   always #(PERIOD / 2.0) clk = ~clk;

endmodule

`default_nettype wire

/* filelist.f */
+incdir+logic
logic/core_pkg.sv
logic/operand_forward.sv
logic/jump_predict.sv
logic/pipe_sequencer.sv
logic/pipe_ctrl_top.sv
bench/tb_clock.sv
bench/pipe_ctrl_tb.sv

/* logic/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data path and address width
`define XLEN_W 32

// register index width, 32 registers per file
`define REG_A_W 5

// retired instruction counter
`define COUNT_W 32

// sequential fetch step, one 32-bit instruction
`define PC_STEP 4

// first fetch address
`define RESET_PC 0

`endif

/* logic/core_pkg.sv */
`default_nettype none

`include "core_defs.svh"

package core_pkg;

   // what one stage knows about the instruction it holds
   typedef struct packed {
      logic [`XLEN_W-1:0]  pc;
      logic [`XLEN_W-1:0]  imm;
      logic [`REG_A_W-1:0] rd;
      logic [`REG_A_W-1:0] rs1;
      logic [`REG_A_W-1:0] rs2;
      logic                uses_reg;
      logic                writes_reg;
      logic                uses_freg;
      logic                writes_freg;
      logic                is_load;
      logic                jal;
      logic                jalr;
   } instr_desc_t;

   typedef struct packed {
      logic [`XLEN_W-1:0] rs1;
      logic [`XLEN_W-1:0] rs2;
   } operand_pair_t;

   // one bit per stage, used for done, valid and start
   typedef struct packed {
      logic fetch;
      logic decode;
      logic exec;
      logic mem;
      logic write;
   } stage_flags_t;

   typedef struct packed {
      logic               taken;
      logic [`XLEN_W-1:0] dest;
   } jump_t;

   // one = producer in exec, two = producer in mem
   typedef struct packed {
      logic int_one;
      logic int_two;
      logic fp_one;
      logic fp_two;
   } fwd_need_t;

   typedef enum logic [2:0] {
      act_advance,
      act_load_stall,
      act_stall_release,
      act_redirect,
      act_predict
   } ctrl_action_e;

endpackage

`default_nettype wire

/* logic/jump_predict.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module jump_predict import core_pkg::*; (
   input  instr_desc_t        dec_desc,
   input  logic [`XLEN_W-1:0] fwd_rs1,
   input  stage_flags_t       stage_valid,
   input  stage_flags_t       stage_done,
   output logic [`XLEN_W-1:0] pred_pc,
   output logic               pred_avail
);

   logic               dec_avail;
   logic               is_jump;
   logic [`XLEN_W-1:0] base;
   logic [`XLEN_W-1:0] offset;

   //////////////////////////////////////////////////////////////////////
   // target
   //////////////////////////////////////////////////////////////////////
   // jal is pc relative, jalr uses rs1 after forwarding
   always_comb begin
      if (dec_desc.jalr) begin
         base = fwd_rs1;
      end else begin
         base = dec_desc.pc;
      end
   end

   // decoder already sign extends imm to full width
   assign offset  = dec_desc.imm;
   assign pred_pc = base + offset;

   //////////////////////////////////////////////////////////////////////
   // availability
   //////////////////////////////////////////////////////////////////////
   assign dec_avail  = stage_valid.decode && stage_done.decode;
   assign is_jump    = dec_desc.jal || dec_desc.jalr;
   assign pred_avail = dec_avail && is_jump;

endmodule

`default_nettype wire

/* logic/operand_forward.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module operand_forward import core_pkg::*; (
   input  instr_desc_t        dec_desc,
   input  instr_desc_t        exe_desc,
   input  instr_desc_t        mem_desc,
   input  operand_pair_t      dec_regs,
   input  operand_pair_t      dec_fregs,
   input  logic [`XLEN_W-1:0] exe_result,
   input  logic [`XLEN_W-1:0] mem_result,
   input  stage_flags_t       stage_valid,
   input  stage_flags_t       stage_done,
   output fwd_need_t          fwd,
   output operand_pair_t      fwd_regs,
   output operand_pair_t      fwd_fregs,
   output logic               load_use
);

   logic exec_avail;
   logic mem_avail;

   // producer writes a register that decode reads
   function automatic logic hazard(
      input logic                dst_uses,
      input logic                src_writes,
      input logic                skip_zero,
      input logic [`REG_A_W-1:0] src_rd,
      input logic [`REG_A_W-1:0] dst_rs1,
      input logic [`REG_A_W-1:0] dst_rs2
   );
      logic hit;
      hit = (src_rd == dst_rs1) || (src_rd == dst_rs2);
      return dst_uses && src_writes && hit && !(skip_zero && src_rd == '0);
   endfunction

   // exec first, then mem, then register file
   function automatic logic [`XLEN_W-1:0] pick(
      input logic                need_one,
      input logic                need_two,
      input logic [`REG_A_W-1:0] rs,
      input logic [`XLEN_W-1:0]  rf_val
   );
      logic [`XLEN_W-1:0] val;
      if (need_one && exec_avail && exe_desc.rd == rs) begin
         val = exe_result;
      end else if (need_two && mem_avail && mem_desc.rd == rs) begin
         val = mem_result;
      end else begin
         val = rf_val;
      end
      return val;
   endfunction

   assign exec_avail = stage_valid.exec && stage_done.exec;
   assign mem_avail  = stage_valid.mem && stage_done.mem;

   //////////////////////////////////////////////////////////////////////
   // hazard detection
   //////////////////////////////////////////////////////////////////////
   // integer x0 is never forwarded, float f0 is a real register
   assign fwd.int_one = hazard(dec_desc.uses_reg, exe_desc.writes_reg, 1'b1,
                               exe_desc.rd, dec_desc.rs1, dec_desc.rs2);
   assign fwd.int_two = hazard(dec_desc.uses_reg, mem_desc.writes_reg, 1'b1,
                               mem_desc.rd, dec_desc.rs1, dec_desc.rs2);
   assign fwd.fp_one  = hazard(dec_desc.uses_freg, exe_desc.writes_freg, 1'b0,
                               exe_desc.rd, dec_desc.rs1, dec_desc.rs2);
   assign fwd.fp_two  = hazard(dec_desc.uses_freg, mem_desc.writes_freg, 1'b0,
                               mem_desc.rd, dec_desc.rs1, dec_desc.rs2);

   // load result not there until mem finishes
   assign load_use = exe_desc.is_load && exec_avail && (fwd.int_one || fwd.fp_one);

   //////////////////////////////////////////////////////////////////////
   // operand select
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      fwd_regs.rs1  = pick(fwd.int_one, fwd.int_two, dec_desc.rs1, dec_regs.rs1);
      fwd_regs.rs2  = pick(fwd.int_one, fwd.int_two, dec_desc.rs2, dec_regs.rs2);
      fwd_fregs.rs1 = pick(fwd.fp_one, fwd.fp_two, dec_desc.rs1, dec_fregs.rs1);
      fwd_fregs.rs2 = pick(fwd.fp_one, fwd.fp_two, dec_desc.rs2, dec_fregs.rs2);
   end

endmodule

`default_nettype wire

/* logic/pipe_ctrl_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module pipe_ctrl_top import core_pkg::*; (
   input  logic                clk,
   input  logic                rstn,
   input  stage_flags_t        stage_done,
   input  instr_desc_t         dec_desc,
   input  instr_desc_t         exe_desc,
   input  instr_desc_t         mem_desc,
   input  operand_pair_t       dec_regs,
   input  operand_pair_t       dec_fregs,
   input  logic [`XLEN_W-1:0]  exe_result,
   input  logic [`XLEN_W-1:0]  mem_result,
   input  jump_t               exe_jump,
   output logic [`XLEN_W-1:0]  pc,
   output stage_flags_t        stage_valid,
   output stage_flags_t        stage_start,
   output operand_pair_t       exe_operands,
   output operand_pair_t       exe_foperands,
   output logic [`COUNT_W-1:0] retired
);

   fwd_need_t          fwd;
   operand_pair_t      fwd_regs;
   operand_pair_t      fwd_fregs;
   logic               load_use;
   logic [`XLEN_W-1:0] pred_pc;
   logic               pred_avail;

   operand_forward u_fwd (
      .dec_desc    (dec_desc),
      .exe_desc    (exe_desc),
      .mem_desc    (mem_desc),
      .dec_regs    (dec_regs),
      .dec_fregs   (dec_fregs),
      .exe_result  (exe_result),
      .mem_result  (mem_result),
      .stage_valid (stage_valid),
      .stage_done  (stage_done),
      .fwd         (fwd),
      .fwd_regs    (fwd_regs),
      .fwd_fregs   (fwd_fregs),
      .load_use    (load_use)
   );

   // jalr base comes from the forwarded rs1
   jump_predict u_pred (
      .dec_desc    (dec_desc),
      .fwd_rs1     (fwd_regs.rs1),
      .stage_valid (stage_valid),
      .stage_done  (stage_done),
      .pred_pc     (pred_pc),
      .pred_avail  (pred_avail)
   );

   pipe_sequencer u_seq (
      .clk           (clk),
      .rstn          (rstn),
      .stage_done    (stage_done),
      .dec_desc      (dec_desc),
      .exe_desc      (exe_desc),
      .exe_jump      (exe_jump),
      .fwd           (fwd),
      .load_use      (load_use),
      .pred_avail    (pred_avail),
      .pred_pc       (pred_pc),
      .fwd_regs      (fwd_regs),
      .fwd_fregs     (fwd_fregs),
      .pc            (pc),
      .stage_valid   (stage_valid),
      .stage_start   (stage_start),
      .exe_operands  (exe_operands),
      .exe_foperands (exe_foperands),
      .retired       (retired)
   );

endmodule

`default_nettype wire

/* logic/pipe_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module pipe_sequencer import core_pkg::*; (
   input  logic               clk,
   input  logic               rstn,
   input  stage_flags_t       stage_done,
   input  instr_desc_t        dec_desc,
   input  instr_desc_t        exe_desc,
   input  jump_t              exe_jump,
   input  fwd_need_t          fwd,
   input  logic               load_use,
   input  logic               pred_avail,
   input  logic [`XLEN_W-1:0] pred_pc,
   input  operand_pair_t      fwd_regs,
   input  operand_pair_t      fwd_fregs,
   output logic [`XLEN_W-1:0] pc,
   output stage_flags_t       stage_valid,
   output stage_flags_t       stage_start,
   output operand_pair_t      exe_operands,
   output operand_pair_t      exe_foperands,
   output logic [`COUNT_W-1:0] retired
);

   logic               stall;
   logic               all_done;
   logic               advance;
   logic               exec_avail;
   logic               mem_avail;
   logic               redirect;
   ctrl_action_e       action;
   logic [`XLEN_W-1:0] pc_next;
   stage_flags_t       valid_next;
   stage_flags_t       start_next;
   logic               latch_en;

   // stage that is not valid counts as done
   assign all_done   = &(stage_done | ~stage_valid);
   assign advance    = all_done;
   assign exec_avail = stage_valid.exec && stage_done.exec;
   assign mem_avail  = stage_valid.mem && stage_done.mem;

   // jal/jalr already went through prediction at decode
   assign redirect = exec_avail && exe_jump.taken && !(exe_desc.jal || exe_desc.jalr);

   //////////////////////////////////////////////////////////////////////
   // action priority
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      if (stall) begin
         action = act_stall_release;
      end else if (load_use) begin
         action = act_load_stall;
      end else if (redirect) begin
         action = act_redirect;
      end else if (pred_avail) begin
         action = act_predict;
      end else begin
         action = act_advance;
      end
   end

   always_comb begin
      pc_next          = pc + `XLEN_W'(`PC_STEP);
      valid_next       = stage_valid;
      valid_next.fetch = 1'b1;
      valid_next.mem   = exec_avail;
      valid_next.write = mem_avail;
      latch_en         = 1'b1;
      unique case (action)
         act_stall_release: begin
            valid_next.exec = 1'b1;
            if (dec_desc.jalr) begin
               pc_next           = pred_pc;
               valid_next.decode = 1'b0;
            end else begin
               valid_next.decode = 1'b1;
            end
         end
         act_load_stall: begin
            // decode runs again with the load result
            pc_next           = pc;
            valid_next.decode = 1'b1;
            valid_next.exec   = 1'b0;
            latch_en          = 1'b0;
         end
         act_redirect: begin
            pc_next           = exe_jump.dest;
            valid_next.decode = 1'b0;
            valid_next.exec   = 1'b0;
            latch_en          = 1'b0;
         end
         act_predict: begin
            pc_next           = pred_pc;
            valid_next.decode = 1'b0;
            valid_next.exec   = 1'b1;
         end
         default: begin
            valid_next.decode = stage_done.fetch;
            valid_next.exec   = stage_done.decode && stage_valid.decode;
         end
      endcase
      start_next       = valid_next;
      // fetched word is kept across the stall
      start_next.fetch = (action != act_load_stall);
   end

   //////////////////////////////////////////////////////////////////////
   // state
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rstn) begin
         pc          <= `XLEN_W'(`RESET_PC);
         stage_valid <= '{fetch: 1'b1, default: 1'b0};
         stage_start <= '{fetch: 1'b1, default: 1'b0};
         stall       <= 1'b0;
         retired     <= '0;
      end else if (advance) begin
         pc          <= pc_next;
         stage_valid <= valid_next;
         stage_start <= start_next;
         stall       <= (action == act_load_stall);
         if (stage_valid.write) begin
            retired <= retired + `COUNT_W'(1);
         end
      end else begin
         stage_start <= '0;
      end
   end

   // operands for the instruction entering exec
   always_ff @(posedge clk) begin
      if (!rstn && advance && latch_en) begin
         exe_operands  <= fwd_regs;
         exe_foperands <= fwd_fregs;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////////////////////////
   a_start_valid: assert property (@(posedge clk) disable iff (rstn)
      (stage_start & ~stage_valid) == '0);

   a_stall_once: assert property (@(posedge clk) disable iff (rstn)
      advance && stall |=> !stall);

   a_reset_pc: assert property (@(posedge clk)
      $fell(rstn) |-> pc == `XLEN_W'(`RESET_PC));

endmodule

`default_nettype wire
